// ==== uartApb.f ====
verilog/uartPkg.sv
verilog/uartLinkIf.sv
verilog/baudTickGen.sv
verilog/uartRec.sv
verilog/uartTrans.sv
verilog/rxFifo.sv
verilog/uartApbRegs.sv
verilog/uartPeriph.sv
testbench/tbClockGen.sv
testbench/uartPeriphTb.sv

// ==== Makefile ====
# Verilator build and run of the APB UART testbench

SIM     = verilator
FLAGS   = --binary --timing --assert
TOP     = uartPeriphTb
FLIST   = uartApb.f
OBJDIR  = obj_dir
LOG     = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build products and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || exit 1

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== testbench/uartPeriphTb.sv ====
// testbench for the apb uart peripheral
// drives the bus and rxd, samples txd, checks against a byte model
`timescale 1ns/1ps
module uartPeriphTb;

	localparam int baudDivSet = 3;	// tick every 4 clocks
	localparam int bitClks = uartPkg::overSample * (baudDivSet + 1);
	localparam int frameLen = uartPkg::dataBits + 2;	// start, data, stop
	localparam int timeoutCycles = 45 * frameLen * bitClks + 2000;

	logic clk, reset;
	logic psel, penable, pwrite;
	logic [uartPkg::apbAddrLen-1:0] paddr;
	logic [31:0] pwdata, prdata;
	logic pready, pslverr;
	logic rxd, txd;

	logic [31:0] lfsrState;
	logic [7:0] rxModel [$];	// bytes DATA reads should return
	logic [frameLen-1:0] txFrames [$];	// frames seen on txd
	logic [frameLen-1:0] txCapture;
	string chkName [$];	// pending compares
	logic [31:0] chkGot [$];
	logic [31:0] chkExp [$];
	string cmpName;
	logic [31:0] cmpGot, cmpExp;
	int cycleCount;

	tbClockGen u_clkGen (.clk(clk), .reset(reset));

	uartPeriph u_dut
	(
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rxd(rxd),
		.txd(txd)
	);

	////////////////////
	// reference model
	function automatic logic [frameLen-1:0] frameBits(input logic [7:0] b);
		return {1'b1, b, 1'b0};	// bit 0 goes out first
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic nextByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			b[i] = lfsrState[0];	// one step per bit
		end
	endtask

	task automatic expectValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		chkName.push_back(name);
		chkGot.push_back(got);
		chkExp.push_back(exp);
	endtask

	////////////////////
	// apb master
	task automatic apbAccess(input logic wr, input logic [uartPkg::apbAddrLen-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);	// setup phase
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;	// access phase
		@(negedge clk);
		while (!pready)
			@(negedge clk);	// wait states
		rdata = prdata;
		err = pslverr;
		@(posedge clk);	// transfer ends on this edge
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic writeReg(input logic [uartPkg::apbAddrLen-1:0] addr,
		input logic [31:0] data, input logic expErr);
		logic [31:0] rd;
		logic err;
		apbAccess(1'b1, addr, data, rd, err);
		expectValue("pslverr", 32'(err), 32'(expErr));
	endtask

	task automatic readReg(input logic [uartPkg::apbAddrLen-1:0] addr,
		input logic [31:0] expData, input logic expErr);
		logic [31:0] rd;
		logic err;
		apbAccess(1'b0, addr, 32'h0, rd, err);
		expectValue("prdata", rd, expData);
		expectValue("pslverr", 32'(err), 32'(expErr));
	endtask

	// poll STATUS until one bit has the wanted value
	task automatic waitStatusBit(input int idx, input logic val);
		logic [31:0] rd;
		logic err;
		apbAccess(1'b0, uartPkg::regStatus, 32'h0, rd, err);
		while (rd[idx] !== val)
			apbAccess(1'b0, uartPkg::regStatus, 32'h0, rd, err);
	endtask

	////////////////////
	// serial line
	task automatic sendFrame(input logic [7:0] b);
		logic [frameLen-1:0] bits;
		bits = frameBits(b);
		@(posedge clk);
		for (int i = 0; i < frameLen; i++)
		begin
			rxd <= bits[i];
			repeat (bitClks) @(posedge clk);
		end
	endtask

	// sampler, bit centres counted from the start edge
	always
	begin
		@(negedge txd);
		for (int i = 0; i < frameLen; i++)
		begin
			repeat ((i == 0) ? bitClks / 2 : bitClks) @(posedge clk);
			txCapture[i] = txd;
		end
		txFrames.push_back(txCapture);
	end

	task automatic checkTxFrame(input logic [7:0] b);
		waitStatusBit(2, 1'b0);	// txBusy low, frame over
		while (txFrames.size() == 0)
			@(posedge clk);
		expectValue("txd frame", 32'(txFrames.pop_front()), 32'(frameBits(b)));
	endtask

	////////////////////
	// compare and timeout
	always @(posedge clk)
	begin
		if (chkName.size() > 0)
		begin
			cmpName = chkName.pop_front();
			cmpGot = chkGot.pop_front();
			cmpExp = chkExp.pop_front();
			assert (cmpGot === cmpExp)
			else
			begin
				$display("Error: %s is 0x%h, expected 0x%h", cmpName, cmpGot, cmpExp);
				$display("Result: FAILED");
				$fatal(1, "stopped at the first mismatch");
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		assert (cycleCount < timeoutCycles)
		else
		begin
			$display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
			$display("Result: FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	initial
	begin : mainSeq
		logic [7:0] b, b2;
		logic [31:0] rd;
		logic err;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rxd = 1'b1;	// line idles high
		cycleCount = 0;
		lfsrState = 32'h46879597;
		@(negedge reset);
		@(negedge clk);
		expectValue("prdata", prdata, 32'h0);
		expectValue("pready", 32'(pready), 32'h0);
		expectValue("pslverr", 32'(pslverr), 32'h0);
		expectValue("txd", 32'(txd), 32'h1);

		// reset values and readback
		readReg(uartPkg::regStatus, 32'h0, 1'b0);
		readReg(uartPkg::regCtrl, 32'h0, 1'b0);
		readReg(uartPkg::regBaudDiv, 32'h0, 1'b0);
		writeReg(uartPkg::regBaudDiv, 32'h0000_BEEF, 1'b0);
		readReg(uartPkg::regBaudDiv, 32'h0000_BEEF, 1'b0);
		writeReg(uartPkg::regBaudDiv, 32'h0, 1'b0);	// stopped, count back at 0
		writeReg(uartPkg::regBaudDiv, 32'(baudDivSet), 1'b0);
		readReg(uartPkg::regBaudDiv, 32'(baudDivSet), 1'b0);
		writeReg(uartPkg::regCtrl, 32'h3, 1'b0);
		readReg(uartPkg::regCtrl, 32'h3, 1'b0);

		// transmit 8 bytes
		for (int i = 0; i < 8; i++)
		begin
			nextByte(b);
			writeReg(uartPkg::regData, 32'(b), 1'b0);
			apbAccess(1'b0, uartPkg::regStatus, 32'h0, rd, err);
			expectValue("txBusy", 32'(rd[2]), 32'h1);
			checkTxFrame(b);
		end

		// refused writes, busy then disabled
		nextByte(b);
		nextByte(b2);
		writeReg(uartPkg::regData, 32'(b), 1'b0);
		writeReg(uartPkg::regData, 32'(b2), 1'b1);	// tx busy
		checkTxFrame(b);
		writeReg(uartPkg::regCtrl, 32'h1, 1'b0);	// rx only
		writeReg(uartPkg::regData, 32'(b2), 1'b1);
		repeat ((frameLen + 1) * bitClks) @(posedge clk);	// long enough to catch a whole frame
		expectValue("txd", 32'(txd), 32'h1);
		expectValue("txFrames count", 32'(txFrames.size()), 32'h0);
		writeReg(uartPkg::regCtrl, 32'h3, 1'b0);

		// receive 8 frames, then read empty
		for (int i = 0; i < 8; i++)
		begin
			nextByte(b);
			rxModel.push_back(b);
			sendFrame(b);
		end
		while (rxModel.size() > 0)
		begin
			waitStatusBit(0, 1'b1);	// rxNotEmpty
			readReg(uartPkg::regData, 32'(rxModel.pop_front()), 1'b0);
		end
		readReg(uartPkg::regData, 32'h0, 1'b1);

		// overflow, 17th byte dropped
		for (int i = 0; i < uartPkg::fifoDepth + 1; i++)
		begin
			nextByte(b);
			if (i < uartPkg::fifoDepth)
				rxModel.push_back(b);
			sendFrame(b);
		end
		readReg(uartPkg::regStatus, 32'hB, 1'b0);	// overrun, full, not empty
		while (rxModel.size() > 0)
			readReg(uartPkg::regData, 32'(rxModel.pop_front()), 1'b0);
		readReg(uartPkg::regStatus, 32'h0, 1'b0);	// overrun cleared

		// receiver disabled ignores the line
		writeReg(uartPkg::regCtrl, 32'h2, 1'b0);
		nextByte(b);
		sendFrame(b);
		readReg(uartPkg::regStatus, 32'h0, 1'b0);

		while (chkName.size() > 0)
			@(posedge clk);
		@(posedge clk);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== testbench/tbClockGen.sv ====
// testbench clock and reset, 8 ns period, reset held for 4 cycles
`timescale 1ns/1ps
module tbClockGen
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 125 MHz
	end

	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;	// released on the 4th edge
	end

endmodule

// ==== verilog/uartPeriph.sv ====
// apb uart peripheral top, ties the bus and serial pins to the blocks
`timescale 1ns/1ps
module uartPeriph
(
	input  logic clk,
	input  logic reset,
	// apb3 slave
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [uartPkg::apbAddrLen-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	// serial pins
	input  logic rxd,
	output logic txd
);

	uartLinkIf link ();

	logic rxDoneTick;	// push into the fifo
	logic [uartPkg::dataBits-1:0] rxByte;

	////////////////////
	// datapath
	baudTickGen u_baudGen (.clk(clk), .reset(reset), .link(link.baud));

	uartRec u_rec (.clk(clk), .reset(reset), .rxd(rxd), .link(link.rx),
		.rxDoneTick(rxDoneTick), .dOut(rxByte));

	uartTrans u_trans (.clk(clk), .reset(reset), .txd(txd), .link(link.tx));

	rxFifo u_rxFifo (.clk(clk), .reset(reset), .push(rxDoneTick),
		.pushData(rxByte), .link(link.rx));

	// bus side
	uartApbRegs u_regs
	(
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.link(link.regs)
	);

endmodule

// ==== verilog/uartApbRegs.sv ====
// apb3 register block of the uart, control, baud divisor and status
// DATA reads take one wait state while the fifo head is captured
`timescale 1ns/1ps
module uartApbRegs
(
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [uartPkg::apbAddrLen-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	uartLinkIf.regs link
);

	uartPkg::regAddr addr;
	logic access;	// access phase
	logic dataRd, dataWr;
	logic wrRefused;	// tx cannot take a byte
	logic dataWait;	// second cycle of a DATA read
	logic [uartPkg::dataBits-1:0] rdHold;	// captured fifo head
	logic rdEmpty;	// fifo was empty at capture
	logic rxOverrun;	// sticky
	logic [31:0] status;

	assign addr = uartPkg::regAddr'(paddr);
	assign access = psel & penable;
	assign dataRd = access & ~pwrite & (addr == uartPkg::regData);
	assign dataWr = access & pwrite & (addr == uartPkg::regData);
	assign wrRefused = link.txBusy | ~link.txEnable;

	// all but DATA reads finish in the first access cycle
	assign pready = access & (~dataRd | dataWait);
	assign pslverr = (dataWr & wrRefused) | (dataRd & dataWait & rdEmpty);

	assign status = {28'b0, rxOverrun, link.txBusy, link.fifoFull, ~link.fifoEmpty};

	////////////////////
	// read mux
	always_comb
	begin
		prdata = '0;
		if (pready & ~pwrite)
		begin
			case (addr)
				uartPkg::regData    : prdata = rdEmpty ? '0 :
					{{(32 - uartPkg::dataBits){1'b0}}, rdHold};
				uartPkg::regStatus  : prdata = status;
				uartPkg::regBaudDiv : prdata = {{(32 - uartPkg::baudDivLen){1'b0}}, link.baudDiv};
				uartPkg::regCtrl    : prdata = {30'b0, link.txEnable, link.rxEnable};
				default             : prdata = '0;	// unmapped offsets
			endcase
		end
	end

	////////////////////
	// control state and pulses
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			link.baudDiv <= '0;
			link.rxEnable <= 1'b0;
			link.txEnable <= 1'b0;
			link.txStart <= 1'b0;
			link.fifoPop <= 1'b0;
			dataWait <= 1'b0;
			rdEmpty <= 1'b0;
			rxOverrun <= 1'b0;
		end
		else
		begin
			link.txStart <= dataWr & ~wrRefused;	// one clock
			link.fifoPop <= dataRd & ~dataWait & ~link.fifoEmpty;	// pops at completion
			dataWait <= dataRd & ~dataWait;
			if (dataRd & ~dataWait)
				rdEmpty <= link.fifoEmpty;
			if (access & pwrite)
			begin
				case (addr)
					uartPkg::regBaudDiv: link.baudDiv <= pwdata[uartPkg::baudDivLen-1:0];
					uartPkg::regCtrl:
					begin
						link.rxEnable <= pwdata[0];
						link.txEnable <= pwdata[1];
					end
					default: ;	// DATA handled by the pulse above
				endcase
			end
			if (link.fifoOverflow)
				rxOverrun <= 1'b1;	// set wins over the clear
			else if (pready & ~pwrite & (addr == uartPkg::regStatus))
				rxOverrun <= 1'b0;	// cleared by reading STATUS
		end
	end

	// byte to send and fifo head
	always_ff @(posedge clk)
	begin
		if (dataWr & ~wrRefused)
			link.txData <= pwdata[uartPkg::dataBits-1:0];
		if (dataRd & ~dataWait)
			rdHold <= link.fifoData;
	end

	// no start into a busy transmitter
	assert property (@(posedge clk) disable iff (reset)
		link.txStart |-> ~link.txBusy);

endmodule

// ==== verilog/rxFifo.sv ====
// receive fifo, 16 bytes deep, drops pushes when full
`timescale 1ns/1ps
module rxFifo
(
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  logic [uartPkg::dataBits-1:0] pushData,
	uartLinkIf.rx link
);

	logic [uartPkg::dataBits-1:0] mem [uartPkg::fifoDepth];
	logic [uartPkg::fifoAddrLen-1:0] wrPtr, rdPtr;	// wrap naturally
	uartPkg::fifoCnt count;	// 0 to fifoDepth
	logic doPush, doPop;

	assign link.fifoEmpty = (count == '0);
	assign link.fifoFull = (count == uartPkg::fifoCnt'(uartPkg::fifoDepth));

	assign doPop = link.fifoPop & ~link.fifoEmpty;
	assign doPush = push & (~link.fifoFull | doPop);	// pop frees a slot
	assign link.fifoOverflow = push & ~doPush;	// byte lost

	assign link.fifoData = mem[rdPtr];	// head entry

	////////////////////
	// storage
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// pointers and fill level
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// none, or both at once
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		count <= uartPkg::fifoCnt'(uartPkg::fifoDepth));

endmodule

// ==== verilog/uartTrans.sv ====
// uart transmitter, start bit, 8 data bits lsb first, one stop bit
// each bit held for 16 sample ticks
`timescale 1ns/1ps
module uartTrans
(
	input  logic clk,
	input  logic reset,
	output logic txd,
	uartLinkIf.tx link
);

	uartPkg::txState stateReg, stateNext;
	uartPkg::tickCnt sReg, sNext;	// ticks within the bit
	uartPkg::bitCnt nReg, nNext;	// data bits sent
	logic [uartPkg::dataBits-1:0] bReg, bNext;	// shifted out lsb first
	logic txReg, txNext;	// registered line, no glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////
	// next state, line value moves with the state
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		case (stateReg)
			uartPkg::txIdle:
			begin
				txNext = 1'b1;
				if (link.txStart & link.txEnable)
				begin
					stateNext = uartPkg::txStart;
					sNext = '0;
					bNext = link.txData;	// latch the byte
					txNext = 1'b0;	// start bit
				end
			end
			uartPkg::txStart:
				if (link.sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::overSample - 1))
					begin
						stateNext = uartPkg::txData;
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::txData:
				if (link.sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::overSample - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == uartPkg::bitCnt'(uartPkg::dataBits - 1))
						begin
							stateNext = uartPkg::txStop;
							txNext = 1'b1;	// stop bit
						end
						else
						begin
							nNext = nReg + 1'b1;
							txNext = bReg[1];	// next bit up
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::txStop:
				if (link.sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::sbTick - 1))
						stateNext = uartPkg::txIdle;	// frame done
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = uartPkg::txIdle;
		endcase
	end

	assign txd = txReg;
	assign link.txBusy = (stateReg != uartPkg::txIdle);

	// line high whenever no start or data bit is on it
	assert property (@(posedge clk) disable iff (reset)
		(stateReg == uartPkg::txIdle || stateReg == uartPkg::txStop) |-> txd);

endmodule

// ==== verilog/uartRec.sv ====
// uart receiver for 16x oversampled 8N1 frames
// checks the start bit at mid-bit, samples data bits at their centres
`timescale 1ns/1ps
module uartRec
(
	input  logic clk,
	input  logic reset,
	input  logic rxd,
	uartLinkIf.rx link,
	output logic rxDoneTick,
	output logic [uartPkg::dataBits-1:0] dOut
);

	uartPkg::rxState stateReg, stateNext;
	uartPkg::tickCnt sReg, sNext;	// sample ticks within a bit
	uartPkg::bitCnt nReg, nNext;	// data bits taken
	logic [uartPkg::dataBits-1:0] bReg, bNext;	// shift reg, lsb first
	logic rxMeta, rxSync;	// line synchronizer

	////////////////////
	// registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::rxIdle;
			sReg <= '0;
			nReg <= '0;
			rxMeta <= 1'b1;	// idle line is high
			rxSync <= 1'b1;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			rxMeta <= rxd;
			rxSync <= rxMeta;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////
	// next state
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			uartPkg::rxIdle:
				if (~rxSync)	// falling start edge
				begin
					stateNext = uartPkg::rxStart;
					sNext = '0;
				end
			uartPkg::rxStart:
				if (link.sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::overSample / 2 - 1))
					begin
						if (~rxSync)	// still low at mid-bit
						begin
							stateNext = uartPkg::rxData;
							sNext = '0;
							nNext = '0;
						end
						else
							stateNext = uartPkg::rxIdle;	// glitch, drop it
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxData:
				if (link.sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::overSample - 1))
					begin
						sNext = '0;
						bNext = {rxSync, bReg[uartPkg::dataBits-1:1]};	// centre sample
						if (nReg == uartPkg::bitCnt'(uartPkg::dataBits - 1))
							stateNext = uartPkg::rxStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxStop:
				if (link.sTick)
				begin
					if (sReg == uartPkg::tickCnt'(uartPkg::sbTick - 1))
					begin
						stateNext = uartPkg::rxIdle;
						rxDoneTick = 1'b1;	// byte ready for the fifo
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = uartPkg::rxIdle;
		endcase
		if (~link.rxEnable)
			stateNext = uartPkg::rxIdle;	// disabled, line ignored
	end

	assign dOut = bReg;

	// done only at a stop tick
	assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> (stateReg == uartPkg::rxStop) && link.sTick);
	// receiver parked while disabled
	assert property (@(posedge clk) disable iff (reset)
		~link.rxEnable |=> (stateReg == uartPkg::rxIdle));

endmodule

// ==== verilog/baudTickGen.sv ====
// baud tick generator, one clock pulse at 16x the baud rate
`timescale 1ns/1ps
module baudTickGen
(
	input  logic clk,
	input  logic reset,
	uartLinkIf.baud link
);

	logic [uartPkg::baudDivLen-1:0] cnt;	// counts down to 0
	logic running;

	assign running = (link.baudDiv != '0);	// divisor 0 means stopped

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= '0;
		else if (~running || cnt == '0)
			cnt <= link.baudDiv;	// reload, period is baudDiv+1
		else
			cnt <= cnt - 1'b1;
	end

	// tick on the zero clock only
	assign link.sTick = running & (cnt == '0);

endmodule

// ==== verilog/uartLinkIf.sv ====
// link between the apb register block and the serial datapath
`timescale 1ns/1ps
interface uartLinkIf;

	// set by the register block
	logic [uartPkg::baudDivLen-1:0] baudDiv;	// 0 stops the tick
	logic rxEnable;
	logic txEnable;
	logic [uartPkg::dataBits-1:0] txData;	// byte to send
	logic txStart;	// one clock
	logic fifoPop;	// one clock

	// datapath status back to the registers
	logic txBusy;
	logic [uartPkg::dataBits-1:0] fifoData;	// head entry
	logic fifoEmpty, fifoFull;
	logic fifoOverflow;	// push dropped, one clock
	logic sTick;	// 16x baud tick

	modport regs (output baudDiv, rxEnable, txEnable, txData, txStart, fifoPop,
		input txBusy, fifoData, fifoEmpty, fifoFull, fifoOverflow);
	modport baud (input baudDiv, output sTick);
	modport tx (input sTick, txEnable, txData, txStart, output txBusy);
	modport rx (input sTick, rxEnable, fifoPop,
		output fifoData, fifoEmpty, fifoFull, fifoOverflow);

endinterface

// ==== verilog/uartPkg.sv ====
// uart peripheral shared sizes, register map and state encodings
// frame format is fixed 8N1 with 16x oversampling
package uartPkg;

	////////////////////
	// frame and sampling
	localparam int dataBits   = 8;	// bits per frame
	localparam int sbTick     = 16;	// ticks in one stop bit
	localparam int overSample = 16;	// ticks per data bit

	// receive fifo
	localparam int fifoDepth   = 16;
	localparam int fifoAddrLen = 4;	// log2 of depth

	// apb side
	localparam int baudDivLen = 16;
	localparam int apbAddrLen = 4;

	// counter types, sized from the constants above
	typedef logic [$clog2(overSample)-1:0] tickCnt;	// sample tick counter
	typedef logic [$clog2(dataBits)-1:0] bitCnt;	// data bit index
	typedef logic [fifoAddrLen:0] fifoCnt;	// one extra bit for full

	////////////////////
	// register offsets
	typedef enum logic [apbAddrLen-1:0] {
		regData    = 4'h0,	// wr sends a byte, rd pops the rx fifo
		regStatus  = 4'h4,	// {rxOverrun, txBusy, rxFull, rxNotEmpty}
		regBaudDiv = 4'h8,	// tick every baudDiv+1 clocks
		regCtrl    = 4'hC	// {txEnable, rxEnable}
	} regAddr;

	// serial state machines
	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState;
	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState;

endpackage
